// File: build.f
logic/ipbus_pkg.sv
logic/fabric_pkg.sv
logic/ipbus_request_decoder.sv
logic/ipbus_register_slave.sv
logic/ipbus_response_encoder.sv
logic/ipbus_endpoint_top.sv
tests/ipbus_endpoint_props.sv
tests/ipbus_endpoint_tb.sv

// File: Bender.yml
package:
  name: ipbus_endpoint

sources:
  # packages first, then the RTL bottom up
  - files:
      - logic/ipbus_pkg.sv
      - logic/fabric_pkg.sv
      - logic/ipbus_request_decoder.sv
      - logic/ipbus_register_slave.sv
      - logic/ipbus_response_encoder.sv
      - logic/ipbus_endpoint_top.sv

  - target: test
    files:
      - tests/ipbus_endpoint_props.sv
      - tests/ipbus_endpoint_tb.sv

// File: tests/ipbus_endpoint_tb.sv
`timescale 1ns/10ps

module ipbus_endpoint_tb;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk_ipbus;
    logic        reset;
    logic        in_tvalid;
    logic [31:0] in_tdata;
    logic        in_tlast;
    logic        in_tready;
    logic        out_tvalid;
    logic [31:0] out_tdata;
    logic        out_tlast;
    logic        out_tready;

    logic [31:0] lfsr_state;
    logic [31:0] reg_model [fabric_pkg::SPACE_WORDS]; // expected register contents
    logic [31:0] no_data [$];
    logic [11:0] next_tid;
    logic        stall_en;                            // out_tready follows the LFSR

    ipbus_endpoint_top u_dut (
        .clk_ipbus  (clk_ipbus),
        .reset      (reset),
        .in_tvalid  (in_tvalid),
        .in_tdata   (in_tdata),
        .in_tlast   (in_tlast),
        .in_tready  (in_tready),
        .out_tvalid (out_tvalid),
        .out_tdata  (out_tdata),
        .out_tlast  (out_tlast),
        .out_tready (out_tready)
    );

    initial begin
        clk_ipbus = 1'b0;
        forever #20 clk_ipbus = ~clk_ipbus;
    end

    // galois form with one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("Fail at time %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_header(input ipbus_pkg::ipbus_word_u got,
                                input ipbus_pkg::ipbus_word_u exp, input string what);
        if (got.hdr.version !== exp.hdr.version)
            report_mismatch({what, " version"}, got.hdr.version, exp.hdr.version);
        if (got.hdr.tid !== exp.hdr.tid)
            report_mismatch({what, " tid"}, got.hdr.tid, exp.hdr.tid);
        if (got.hdr.words !== exp.hdr.words)
            report_mismatch({what, " words"}, got.hdr.words, exp.hdr.words);
        if (got.hdr.ttype !== exp.hdr.ttype)
            report_mismatch({what, " type"}, got.hdr.ttype, exp.hdr.ttype);
        if (got.hdr.info !== exp.hdr.info)
            report_mismatch({what, " info"}, got.hdr.info, exp.hdr.info);
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    // the bound checker counts its failed handshake assertions
    always @(posedge clk_ipbus) begin
        if (u_dut.u_props.assert_failures != 0) begin
            abort_run("A handshake assertion failed");
        end
    end

    task automatic send_packet(input logic [31:0] words [$]);
        int wait_cycles;
        for (int i = 0; i < words.size(); i++) begin
            in_tvalid <= 1'b1;
            in_tdata  <= words[i];
            in_tlast  <= (i == words.size() - 1);
            wait_cycles = 0;
            do begin
                @(posedge clk_ipbus);
                wait_cycles++;
                if (wait_cycles > TIMEOUT_CYCLES)
                    abort_run("Timeout: the DUT never accepted an input word");
            end while (!in_tready);
        end
        in_tvalid <= 1'b0;
        in_tlast  <= 1'b0;
    endtask

    task automatic collect_response(output logic [31:0] resp [$]);
        int   idle_cycles;
        logic done;
        resp = {};
        done = 1'b0;
        idle_cycles = 0;
        while (!done) begin
            out_tready <= stall_en ? (random_bits(1) != 0) : 1'b1;
            @(posedge clk_ipbus);
            if (out_tvalid && out_tready) begin
                resp.push_back(out_tdata);
                done = out_tlast; // response ends on last
                idle_cycles = 0;
            end else begin
                idle_cycles++;
                if (idle_cycles > TIMEOUT_CYCLES)
                    abort_run("Timeout: the DUT stopped sending response words");
            end
        end
        out_tready <= 1'b0;
    endtask

    task automatic make_write_data(input int n, output logic [31:0] data [$]);
        data = {};
        for (int i = 0; i < n; i++) data.push_back(random_bits(32));
    endtask

    // one request packet and its response checked against the register model
    task automatic run_transaction(input logic [3:0] hdr_version, input logic [3:0] hdr_info,
                                   input logic [3:0] hdr_type, input logic [7:0] n_words,
                                   input logic [31:0] base, input logic [31:0] wdata [$],
                                   input logic [3:0] exp_info);
        ipbus_pkg::ipbus_word_u req;
        ipbus_pkg::ipbus_word_u exp;
        logic [31:0]            pkt [$];
        logic [31:0]            resp [$];
        int                     n_data;
        req.hdr = '{version: hdr_version, tid: next_tid, words: n_words,
                    ttype: hdr_type, info: hdr_info};
        pkt = {req.data, base};
        foreach (wdata[i]) pkt.push_back(wdata[i]);
        send_packet(pkt);
        collect_response(resp);
        exp.hdr = '{version: ipbus_pkg::IPBUS_VERSION, tid: next_tid,
                    words: (exp_info == ipbus_pkg::INFO_OK) ? n_words : 8'd0,
                    ttype: hdr_type, info: exp_info};
        check_header(resp[0], exp, "response header");
        n_data = (exp_info == ipbus_pkg::INFO_OK && hdr_type == ipbus_pkg::TYPE_READ) ? n_words : 0;
        check_data(resp.size(), 1 + n_data, "response length");
        for (int i = 0; i < n_data; i++) begin
            check_data(resp[1 + i], reg_model[base + i], $sformatf("read word at %0d", base + i));
        end
        if (exp_info == ipbus_pkg::INFO_OK && hdr_type == ipbus_pkg::TYPE_WRITE) begin
            for (int i = 0; i < n_words && i < wdata.size(); i++) reg_model[base + i] = wdata[i];
        end
        next_tid++;
    endtask

    task automatic read_after_reset();
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_READ,
                        8'd16, 32'd0, no_data, ipbus_pkg::INFO_OK); // model is all zero here
    endtask

    task automatic write_then_read_back();
        logic [31:0] data [$];
        make_write_data(16, data);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_WRITE,
                        8'd16, 32'd0, data, ipbus_pkg::INFO_OK);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_READ,
                        8'd16, 32'd0, no_data, ipbus_pkg::INFO_OK);
        make_write_data(6, data);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_WRITE,
                        8'd6, 32'd5, data, ipbus_pkg::INFO_OK); // crosses slaves 1 and 2
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_READ,
                        8'd16, 32'd0, no_data, ipbus_pkg::INFO_OK);
    endtask

    task automatic reject_bad_address();
        logic [31:0] data [$];
        make_write_data(4, data);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_WRITE,
                        8'd4, 32'd14, data, ipbus_pkg::INFO_BAD_ADDRESS);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_READ,
                        8'd1, 32'd16, no_data, ipbus_pkg::INFO_BAD_ADDRESS);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_READ,
                        8'd16, 32'd0, no_data, ipbus_pkg::INFO_OK);
    endtask

    task automatic reject_bad_header();
        logic [31:0] data [$];
        run_transaction(4'd1, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_READ,
                        8'd1, 32'd0, no_data, ipbus_pkg::INFO_BAD_HEADER);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_OK, ipbus_pkg::TYPE_READ,
                        8'd1, 32'd0, no_data, ipbus_pkg::INFO_BAD_HEADER);
        make_write_data(2, data);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, 4'd5,
                        8'd2, 32'd0, data, ipbus_pkg::INFO_BAD_HEADER); // trailing words dropped
        make_write_data(2, data);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_WRITE,
                        8'd2, 32'd3, data, ipbus_pkg::INFO_OK);
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_READ,
                        8'd4, 32'd2, no_data, ipbus_pkg::INFO_OK);
    endtask

    task automatic read_under_stall();
        stall_en = 1'b1;
        run_transaction(ipbus_pkg::IPBUS_VERSION, ipbus_pkg::INFO_REQUEST, ipbus_pkg::TYPE_READ,
                        8'd16, 32'd0, no_data, ipbus_pkg::INFO_OK);
        stall_en = 1'b0;
    endtask

    initial begin
        reset      = 1'b1;
        in_tvalid  = 1'b0;
        in_tdata   = '0;
        in_tlast   = 1'b0;
        out_tready = 1'b0;
        lfsr_state = 32'h2985;
        next_tid   = 12'h100;
        stall_en   = 1'b0;
        for (int i = 0; i < fabric_pkg::SPACE_WORDS; i++) reg_model[i] = '0;
        repeat (5) @(posedge clk_ipbus);
        reset <= 1'b0;
        read_after_reset();
        write_then_read_back();
        reject_bad_address();
        reject_bad_header();
        read_under_stall();
        if (u_dut.u_props.assert_failures != 0) begin
            abort_run("Handshake assertions failed during the run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: tests/ipbus_endpoint_props.sv
`timescale 1ns/10ps

module ipbus_endpoint_props (
    input logic                              clk_ipbus,
    input logic                              reset,
    input logic [fabric_pkg::NUM_SLAVES-1:0] acc_req,
    input logic                              acc_done,
    input logic                              hdr_req,
    input logic                              hdr_ack,
    input logic                              out_tvalid,
    input logic [31:0]                       out_tdata,
    input logic                              out_tready
);

    int assert_failures = 0; // failed assertions so far

    a_req_onehot: assert property (@(posedge clk_ipbus) disable iff (reset)
        $onehot0(acc_req))
        else begin
            $error("more than one slave request high: %b", acc_req);
            assert_failures++;
        end

    // four-phase request stays put until the encoder reports done
    a_req_hold: assert property (@(posedge clk_ipbus) disable iff (reset)
        (|acc_req && !acc_done) |=> (acc_req == $past(acc_req)))
        else begin
            $error("acc_req changed before acc_done");
            assert_failures++;
        end

    a_out_stable: assert property (@(posedge clk_ipbus) disable iff (reset)
        (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata)))
        else begin
            $error("output word changed while stalled");
            assert_failures++;
        end

    a_hdr_hold: assert property (@(posedge clk_ipbus) disable iff (reset)
        (hdr_req && !hdr_ack) |=> hdr_req)
        else begin
            $error("hdr_req dropped before hdr_ack");
            assert_failures++;
        end

endmodule

bind ipbus_endpoint_top ipbus_endpoint_props u_props (
    .clk_ipbus  (clk_ipbus),
    .reset      (reset),
    .acc_req    (acc_req),
    .acc_done   (acc_done),
    .hdr_req    (hdr_req),
    .hdr_ack    (hdr_ack),
    .out_tvalid (out_tvalid),
    .out_tdata  (out_tdata),
    .out_tready (out_tready)
);

// File: logic/ipbus_endpoint_top.sv
`timescale 1ns/10ps

module ipbus_endpoint_top (
    input  logic        clk_ipbus,
    input  logic        reset,
    input  logic        in_tvalid,
    input  logic [31:0] in_tdata,
    input  logic        in_tlast,
    output logic        in_tready,
    output logic        out_tvalid,
    output logic [31:0] out_tdata,
    output logic        out_tlast,
    input  logic        out_tready
);

    logic [fabric_pkg::NUM_SLAVES-1:0]       acc_req;
    logic                                    acc_we;
    logic [fabric_pkg::REG_W-1:0]            acc_reg;
    logic [31:0]                             acc_wdata;
    logic [fabric_pkg::NUM_SLAVES-1:0]       acc_ack;
    logic [fabric_pkg::NUM_SLAVES-1:0][31:0] acc_rdata;
    logic                                    acc_done;
    logic                                    hdr_req;
    logic                                    hdr_ack;
    ipbus_pkg::ipbus_word_u                  hdr_word;

    ipbus_request_decoder decoder (
        .clk_ipbus (clk_ipbus),
        .reset     (reset),
        .in_tvalid (in_tvalid),
        .in_tdata  (in_tdata),
        .in_tlast  (in_tlast),
        .in_tready (in_tready),
        .acc_req   (acc_req),
        .acc_we    (acc_we),
        .acc_reg   (acc_reg),
        .acc_wdata (acc_wdata),
        .acc_done  (acc_done),
        .hdr_req   (hdr_req),
        .hdr_word  (hdr_word),
        .hdr_ack   (hdr_ack)
    );

    // one register bank per slave select value
    for (genvar k = 0; k < fabric_pkg::NUM_SLAVES; k++) begin : g_slave
        ipbus_register_slave slave (
            .clk_ipbus (clk_ipbus),
            .reset     (reset),
            .req       (acc_req[k]),
            .we        (acc_we),
            .reg_sel   (acc_reg),
            .wdata     (acc_wdata),
            .ack       (acc_ack[k]),
            .rdata     (acc_rdata[k])
        );
    end

    ipbus_response_encoder encoder (
        .clk_ipbus  (clk_ipbus),
        .reset      (reset),
        .hdr_req    (hdr_req),
        .hdr_word   (hdr_word),
        .hdr_ack    (hdr_ack),
        .acc_ack    (acc_ack),
        .acc_rdata  (acc_rdata),
        .acc_done   (acc_done),
        .out_tvalid (out_tvalid),
        .out_tdata  (out_tdata),
        .out_tlast  (out_tlast),
        .out_tready (out_tready)
    );

endmodule

// File: logic/ipbus_response_encoder.sv
`timescale 1ns/10ps

module ipbus_response_encoder (
    input  logic                                     clk_ipbus,
    input  logic                                     reset,
    input  logic                                     hdr_req,
    input  ipbus_pkg::ipbus_word_u                   hdr_word,
    output logic                                     hdr_ack,
    input  logic [fabric_pkg::NUM_SLAVES-1:0]        acc_ack,
    input  logic [fabric_pkg::NUM_SLAVES-1:0][31:0]  acc_rdata,
    output logic                                     acc_done,
    output logic                                     out_tvalid,
    output logic [31:0]                              out_tdata,
    output logic                                     out_tlast,
    input  logic                                     out_tready
);

    logic [7:0]  rd_left;      // read words still to send
    logic [7:0]  expect_words;
    logic [31:0] rd_word;
    logic        hdr_busy;     // header sits in the output register
    logic        rd_pend;      // read word sits in the output register
    logic        rd_done;      // read word sent, done held until ack falls
    logic        read_txn;
    logic        ack_any;
    logic        out_xfer;
    logic        hdr_load;
    logic        rd_load;

    assign ack_any  = |acc_ack;
    assign out_xfer = out_tvalid & out_tready;
    assign read_txn = (rd_left != 8'd0) | rd_done;

    // writes complete on ack, reads only once their word is out
    assign acc_done = read_txn ? rd_done : ack_any;

    // only an accepted read carries data words
    assign expect_words = (hdr_word.hdr.ttype == ipbus_pkg::TYPE_READ &&
                           hdr_word.hdr.info == ipbus_pkg::INFO_OK) ? hdr_word.hdr.words : 8'd0;

    assign hdr_load = hdr_req & ~hdr_ack & ~hdr_busy & ~out_tvalid;
    assign rd_load  = ack_any & read_txn & ~rd_pend & ~rd_done & ~out_tvalid;

    always_comb begin
        rd_word = '0;
        for (int k = 0; k < fabric_pkg::NUM_SLAVES; k++) begin
            if (acc_ack[k]) rd_word = rd_word | acc_rdata[k]; // one-hot select
        end
    end

    always_ff @(posedge clk_ipbus) begin
        if (reset) begin
            out_tvalid <= 1'b0;
            out_tlast  <= 1'b0;
            hdr_ack    <= 1'b0;
            hdr_busy   <= 1'b0;
            rd_left    <= '0;
            rd_pend    <= 1'b0;
            rd_done    <= 1'b0;
        end else begin
            if (hdr_ack && !hdr_req) hdr_ack <= 1'b0;
            if (!ack_any) rd_done <= 1'b0;

            if (out_xfer) begin
                out_tvalid <= 1'b0;
                if (hdr_busy) begin
                    hdr_busy <= 1'b0;
                    hdr_ack  <= 1'b1; // header is out, close the hand-off
                end
                if (rd_pend) begin
                    rd_pend <= 1'b0;
                    rd_done <= 1'b1;
                    rd_left <= rd_left - 8'd1;
                end
            end

            // header always goes first, data follows in access order
            if (hdr_load) begin
                out_tvalid <= 1'b1;
                out_tdata  <= hdr_word.data;
                out_tlast  <= (expect_words == 8'd0);
                hdr_busy   <= 1'b1;
                rd_left    <= expect_words;
            end else if (rd_load) begin
                out_tvalid <= 1'b1;
                out_tdata  <= rd_word;
                out_tlast  <= (rd_left == 8'd1);
                rd_pend    <= 1'b1;
            end
        end
    end

endmodule

// File: logic/ipbus_register_slave.sv
`timescale 1ns/10ps

module ipbus_register_slave (
    input  logic                         clk_ipbus,
    input  logic                         reset,
    input  logic                         req,
    input  logic                         we,
    input  logic [fabric_pkg::REG_W-1:0] reg_sel,
    input  logic [31:0]                  wdata,
    output logic                         ack,
    output logic [31:0]                  rdata
);

    logic [31:0] regs [fabric_pkg::REGS_PER_SLAVE];
    logic        start;

    // a request is served once, on the edge where ack rises
    assign start = req & ~ack;

    always_ff @(posedge clk_ipbus) begin
        if (reset) begin
            ack <= 1'b0;
            for (int i = 0; i < fabric_pkg::REGS_PER_SLAVE; i++) begin
                regs[i] <= '0;
            end
        end else begin
            ack <= req; // follows req one cycle late, both edges
            if (start && we) begin
                regs[reg_sel] <= wdata;
            end
        end
    end

    // read word stays stable while ack is high
    always_ff @(posedge clk_ipbus) begin
        if (start) begin
            rdata <= regs[reg_sel];
        end
    end

endmodule

// File: logic/ipbus_request_decoder.sv
`timescale 1ns/10ps

module ipbus_request_decoder (
    input  logic                                 clk_ipbus,
    input  logic                                 reset,
    input  logic                                 in_tvalid,
    input  ipbus_pkg::ipbus_word_u               in_tdata,
    input  logic                                 in_tlast,
    output logic                                 in_tready,
    output logic [fabric_pkg::NUM_SLAVES-1:0]    acc_req,
    output logic                                 acc_we,
    output logic [fabric_pkg::REG_W-1:0]         acc_reg,
    output logic [31:0]                          acc_wdata,
    input  logic                                 acc_done,
    output logic                                 hdr_req,
    output ipbus_pkg::ipbus_word_u               hdr_word,
    input  logic                                 hdr_ack
);

    typedef enum logic [2:0] {S_IDLE, S_ADDR, S_RESP, S_READ, S_WDATA} state_t;

    state_t                          state;
    ipbus_pkg::ipbus_hdr_t           rx_hdr;    // request header as received
    logic [3:0]                      info_q;    // response info code
    logic [fabric_pkg::ADDR_W-1:0]   addr_q;    // address of the next access
    logic [7:0]                      remain_q;  // accesses still to run
    logic                            pkt_last;  // input packet already ended
    logic                            acc_wait;  // req dropped, waiting for done low
    logic                            acc_open;
    logic                            acc_start;
    logic                            in_xfer;
    logic                            hdr_bad;
    logic                            range_bad;
    logic [32:0]                     range_end;

    assign acc_open = (|acc_req) | acc_wait;
    assign in_xfer  = in_tvalid & in_tready;

    assign hdr_bad = (rx_hdr.version != ipbus_pkg::IPBUS_VERSION) |
                     (rx_hdr.info != ipbus_pkg::INFO_REQUEST) |
                     ((rx_hdr.ttype != ipbus_pkg::TYPE_READ) &
                      (rx_hdr.ttype != ipbus_pkg::TYPE_WRITE));

    // base + words checked against the space, one bit wider so it cannot wrap
    assign range_end = {1'b0, in_tdata.data} + 33'(rx_hdr.words);
    assign range_bad = range_end > 33'(fabric_pkg::SPACE_WORDS);

    assign acc_start = (remain_q != 8'd0) &
                       (((state == S_READ) & ~acc_open) | ((state == S_WDATA) & in_xfer));

    always_ff @(posedge clk_ipbus) begin
        if (reset) begin
            state     <= S_IDLE;
            in_tready <= 1'b0;
            acc_req   <= '0;
            acc_we    <= 1'b0;
            acc_wait  <= 1'b0;
            hdr_req   <= 1'b0;
            pkt_last  <= 1'b0;
            remain_q  <= '0;
            addr_q    <= '0;
            info_q    <= '0;
        end else begin
            if (state == S_IDLE) in_tready <= 1'b1; // leaving reset
            if (hdr_req && hdr_ack) hdr_req <= 1'b0;

            if (acc_start) begin
                acc_req   <= {{(fabric_pkg::NUM_SLAVES-1){1'b0}}, 1'b1} <<
                             addr_q[fabric_pkg::ADDR_W-1:fabric_pkg::REG_W];
                acc_we    <= (state == S_WDATA);
                acc_reg   <= addr_q[fabric_pkg::REG_W-1:0];
                acc_wdata <= in_tdata.data;
                addr_q    <= addr_q + 1'b1;
                remain_q  <= remain_q - 8'd1;
            end
            if (|acc_req && acc_done) begin
                acc_req  <= '0;
                acc_wait <= 1'b1;
            end
            if (acc_wait && !acc_done) acc_wait <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (in_xfer) begin
                        rx_hdr <= in_tdata.hdr;
                        if (!in_tlast) state <= S_ADDR; // header-only packets are dropped
                    end
                end
                S_ADDR: begin
                    if (in_xfer) begin
                        in_tready <= 1'b0;
                        pkt_last  <= in_tlast;
                        addr_q    <= in_tdata.data[fabric_pkg::ADDR_W-1:0];
                        state     <= S_RESP;
                        if (hdr_bad) begin
                            info_q   <= ipbus_pkg::INFO_BAD_HEADER;
                            remain_q <= '0;
                        end else if (range_bad) begin
                            info_q   <= ipbus_pkg::INFO_BAD_ADDRESS;
                            remain_q <= '0;
                        end else begin
                            info_q   <= ipbus_pkg::INFO_OK;
                            remain_q <= rx_hdr.words;
                        end
                    end
                end
                S_RESP: begin
                    // previous header hand-off must be fully closed
                    if (!hdr_req && !hdr_ack) begin
                        hdr_req      <= 1'b1;
                        hdr_word.hdr <= '{version: ipbus_pkg::IPBUS_VERSION,
                                         tid:     rx_hdr.tid,
                                         words:   (info_q == ipbus_pkg::INFO_OK) ?
                                                  rx_hdr.words : 8'd0,
                                         ttype:   rx_hdr.ttype,
                                         info:    info_q};
                        if (rx_hdr.ttype == ipbus_pkg::TYPE_READ && remain_q != 8'd0) begin
                            state <= S_READ;
                        end else begin
                            in_tready <= 1'b1;
                            pkt_last  <= 1'b0;
                            state     <= pkt_last ? S_IDLE : S_WDATA;
                        end
                    end
                end
                S_READ: begin
                    if (acc_wait && !acc_done && remain_q == 8'd0) begin
                        in_tready <= 1'b1;
                        pkt_last  <= 1'b0;
                        state     <= pkt_last ? S_IDLE : S_WDATA; // drain any trailing words
                    end
                end
                S_WDATA: begin
                    // with nothing left to write this state just drains up to last
                    if (in_xfer) begin
                        if (remain_q != 8'd0) begin
                            in_tready <= 1'b0;
                            pkt_last  <= in_tlast;
                        end else if (in_tlast) begin
                            state <= S_IDLE;
                        end
                    end
                    if (acc_wait && !acc_done) begin
                        in_tready <= 1'b1;
                        if (pkt_last) begin
                            pkt_last <= 1'b0; // short packet drops missing writes
                            state    <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: logic/fabric_pkg.sv
package fabric_pkg;

    // register fabric behind the endpoint
    localparam int NUM_SLAVES     = 4;
    localparam int REGS_PER_SLAVE = 4;

    // address word split: slave in [3:2], register in [1:0]
    localparam int SLAVE_W = 2;
    localparam int REG_W   = 2;
    localparam int ADDR_W  = SLAVE_W + REG_W;

    // total number of addressable words
    localparam int SPACE_WORDS = NUM_SLAVES * REGS_PER_SLAVE;

endpackage

// File: logic/ipbus_pkg.sv
package ipbus_pkg;

    // protocol version carried in every header
    localparam logic [3:0] IPBUS_VERSION = 4'd2;

    // transaction types
    localparam logic [3:0] TYPE_READ  = 4'd0;
    localparam logic [3:0] TYPE_WRITE = 4'd1;

    // info codes, request in and response out
    localparam logic [3:0] INFO_REQUEST     = 4'hf;
    localparam logic [3:0] INFO_OK          = 4'h0;
    localparam logic [3:0] INFO_BAD_HEADER  = 4'h1; // version, info or type wrong
    localparam logic [3:0] INFO_BAD_ADDRESS = 4'h4; // range leaves the register space

    // transaction header as it sits in a stream word
    typedef struct packed {
        logic [3:0]  version; // [31:28]
        logic [11:0] tid;     // echoed in the response
        logic [7:0]  words;   // number of single-word accesses
        logic [3:0]  ttype;
        logic [3:0]  info;
    } ipbus_hdr_t;

    // one stream word, seen as header or as plain data by its place in the packet
    typedef union packed {
        ipbus_hdr_t  hdr;
        logic [31:0] data;
    } ipbus_word_u;

endpackage
